// File: bench/pdsch_beam_reduce_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pdsch_beam_reduce_tb;

    // 4 bank loads of 33 cycles, about 165 REs, up to 24 idle cycles, reset and drain
    localparam int STIM_CYCLES = 400;
    localparam int TIMEOUT     = 2 * STIM_CYCLES + 100;

    logic                                           i_clk;
    logic                                           i_reset;
    logic                                           i_cw_wr;
    beam_pkg::cw_addr_t                             i_cw_addr;
    beam_pkg::weight_t                              i_cw_data;
    logic                                           i_valid;
    logic                                           i_sym_start;
    rbg_pkg::rbg_size_e                             i_rbg_size;
    beam_pkg::sample_t [beam_pkg::NUM_ANT-1:0]      i_ant_data;
    logic                                           o_valid;
    rbg_pkg::rbg_num_t                              o_rbg_num;
    beam_pkg::beam_idx_t                            o_beam_idx;
    beam_pkg::energy_t                              o_beam_energy;

    // reference model state
    beam_pkg::weight_t w_ref [beam_pkg::NUM_ANT*beam_pkg::NUM_BEAM];
    beam_pkg::sample_t re_buf [rbg_pkg::RBG_RE_MAX*beam_pkg::NUM_ANT];   // REs of the open RBG
    int     re_cnt;
    int     rbg_len;
    int     rbg_num;
    int     cycle_cnt;
    int     drain_cnt;
    integer seed;
    integer seed_save;
    integer gap_seed;
    longint exp_num [$];
    longint exp_idx [$];
    longint exp_energy [$];

    pdsch_beam_reduce u_dut (
        .i_clk(i_clk), .i_reset(i_reset),
        .i_cw_wr(i_cw_wr), .i_cw_addr(i_cw_addr), .i_cw_data(i_cw_data),
        .i_valid(i_valid), .i_sym_start(i_sym_start), .i_rbg_size(i_rbg_size),
        .i_ant_data(i_ant_data),
        .o_valid(o_valid), .o_rbg_num(o_rbg_num),
        .o_beam_idx(o_beam_idx), .o_beam_energy(o_beam_energy)
    );

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    // ----------------------------------------------------------------------
    // reference model and compare
    // ----------------------------------------------------------------------
    // energy of the winning beam over n_re buffered REs
    function automatic longint best_beam(input int n_re, output int idx);
        longint best;
        longint e;
        longint s;
        best = -1;
        idx  = 0;
        for (int b = 0; b < beam_pkg::NUM_BEAM; b++) begin
            e = 0;
            for (int r = 0; r < n_re; r++) begin
                s = 0;
                for (int a = 0; a < beam_pkg::NUM_ANT; a++) begin
                    s += longint'(re_buf[r*4 + a]) * longint'(w_ref[b*4 + a]);
                end
                e += (s < 0) ? -s : s;      // magnitude of the beam sum
            end
            if (e > best) begin             // strict, so a tie keeps the lower beam
                best = e;
                idx  = b;
            end
        end
        return best;
    endfunction

    task automatic check(input string name, input longint got, input longint exp);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
            $display("Simulation FAILED");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    always @(negedge i_clk) begin
        if (o_valid) begin
            if (exp_num.size() == 0) begin
                $display("o_valid raised with no RBG result expected");
                $display("Simulation FAILED");
                $fatal(1, "unexpected output");
            end else begin
                check("o_rbg_num", o_rbg_num, exp_num.pop_front());
                check("o_beam_idx", o_beam_idx, exp_idx.pop_front());
                check("o_beam_energy", o_beam_energy, exp_energy.pop_front());
            end
        end
    end

    always @(posedge i_clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT) begin
            $display("run did not finish within %0d cycles", TIMEOUT);
            $display("Simulation FAILED");
            $fatal(1, "timeout");
        end
    end

    // ----------------------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------------------
    task automatic load_bank();
        for (int i = 0; i < beam_pkg::NUM_ANT*beam_pkg::NUM_BEAM; i++) begin
            @(negedge i_clk);
            i_cw_wr   = 1'b1;
            i_cw_addr = beam_pkg::cw_addr_t'(i);
            i_cw_data = w_ref[i];
        end
        @(negedge i_clk);
        i_cw_wr = 1'b0;
    endtask

    // kind 0 random samples, 1 constant, 2 negative only
    task automatic send_re(input bit sym, input rbg_pkg::rbg_size_e sz, input bit gaps,
                           input int kind);
        int     idx;
        longint e;
        if (gaps && ($random(gap_seed) & 1)) begin
            @(negedge i_clk);
            i_valid     = 1'b0;
            i_sym_start = 1'b0;
        end
        @(negedge i_clk);
        i_valid     = 1'b1;
        i_sym_start = sym;
        i_rbg_size  = sz;
        if (sym) begin                      // open RBG of the old symbol is dropped
            re_cnt  = 0;
            rbg_num = 0;
            rbg_len = (sz == rbg_pkg::RBG_SIZE_16) ? 16 : (sz == rbg_pkg::RBG_SIZE_8) ? 8 : 4;
        end
        for (int a = 0; a < beam_pkg::NUM_ANT; a++) begin
            case (kind)
                0:       i_ant_data[a] = beam_pkg::sample_t'($random(seed));
                1:       i_ant_data[a] = 16'sd1000;
                default: i_ant_data[a] = beam_pkg::sample_t'(-1 - ($random(seed) & 32'h7fff));
            endcase
            re_buf[re_cnt*4 + a] = i_ant_data[a];
        end
        re_cnt++;
        if (re_cnt == rbg_len) begin
            e = best_beam(rbg_len, idx);
            exp_num.push_back(rbg_num);
            exp_idx.push_back(idx);
            exp_energy.push_back(e);
            re_cnt = 0;
            rbg_num++;
        end
    endtask

    task automatic send_symbol(input rbg_pkg::rbg_size_e sz, input int n_re, input bit gaps,
                               input int kind);
        for (int r = 0; r < n_re; r++) begin
            send_re(r == 0, sz, gaps, kind);
        end
        @(negedge i_clk);
        i_valid     = 1'b0;
        i_sym_start = 1'b0;
    endtask

    initial begin
        seed        = 88698;
        gap_seed    = seed + 1;             // own stream for the idle pattern
        cycle_cnt   = 0;
        drain_cnt   = 0;
        re_cnt      = 0;
        rbg_len     = 4;
        rbg_num     = 0;
        i_reset     = 1'b1;
        i_cw_wr     = 1'b0;
        i_cw_addr   = '0;
        i_cw_data   = '0;
        i_valid     = 1'b0;
        i_sym_start = 1'b0;
        i_rbg_size  = rbg_pkg::RBG_SIZE_4;
        i_ant_data  = '0;
        repeat (8) @(negedge i_clk);
        i_reset = 1'b0;

        // beam 5 dominates under constant samples
        for (int i = 0; i < 32; i++) begin
            w_ref[i] = (i / 4 == 5) ? 8'sd90 : beam_pkg::weight_t'(i - 16);
        end
        load_bank();
        send_symbol(rbg_pkg::RBG_SIZE_4, 12, 1'b0, 1);

        // random weights, all three RBG sizes
        for (int i = 0; i < 32; i++) w_ref[i] = beam_pkg::weight_t'($random(seed));
        load_bank();
        send_symbol(rbg_pkg::RBG_SIZE_4, 12, 1'b0, 0);
        seed_save = seed;
        send_symbol(rbg_pkg::RBG_SIZE_8, 24, 1'b0, 0);
        send_symbol(rbg_pkg::RBG_SIZE_16, 48, 1'b0, 0);

        // same size 8 REs again with idle cycles in between
        seed = seed_save;
        send_symbol(rbg_pkg::RBG_SIZE_8, 24, 1'b1, 0);

        // negative weights and samples
        for (int i = 0; i < 32; i++) w_ref[i] = beam_pkg::weight_t'(-1 - ($random(seed) & 127));
        load_bank();
        send_symbol(rbg_pkg::RBG_SIZE_4, 8, 1'b0, 2);
        send_symbol(rbg_pkg::RBG_SIZE_4, 8, 1'b0, 1);     // every beam sum negative

        // beams 2 and 6 identical and strongest
        for (int i = 0; i < 32; i++) begin
            w_ref[i] = (i / 4 == 2 || i / 4 == 6) ? beam_pkg::weight_t'(100 - i % 4)
                                                  : beam_pkg::weight_t'(i % 4 + 1);
        end
        load_bank();
        send_symbol(rbg_pkg::RBG_SIZE_8, 8, 1'b0, 1);

        // partial second RBG, then a new symbol restarts at RBG 0
        send_symbol(rbg_pkg::RBG_SIZE_8, 11, 1'b0, 0);
        send_symbol(rbg_pkg::RBG_SIZE_4, 8, 1'b0, 0);

        // last RBG is due 4 cycles after its final RE
        while (exp_num.size() != 0 && drain_cnt < 8) begin
            @(negedge i_clk);
            drain_cnt++;
        end
        repeat (10) @(negedge i_clk);      // no stray outputs after the last RBG
        if (exp_num.size() == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            $display("expected RBG results were never produced");
            $display("Simulation FAILED");
            $fatal(1, "missing outputs");
        end
    end

endmodule

`default_nettype wire

// File: pdsch_beam_reduce.f
source/beam_pkg.sv
source/rbg_pkg.sv
source/cw_bank.sv
source/beam_mac.sv
source/rbg_accumulator.sv
source/beam_select.sv
source/pdsch_beam_reduce.sv
bench/pdsch_beam_reduce_tb.sv

// File: source/beam_mac.sv
`timescale 1ns/1ps
`default_nettype none

module beam_mac (
    input  wire                         i_clk,
    input  wire                         i_reset,

    // RE stream in
    input  wire                         i_valid,
    input  wire                         i_sym_start,
    input  wire beam_pkg::sample_t [beam_pkg::NUM_ANT-1:0] i_ant_data,

    // codewords from the bank
    input  wire beam_pkg::weight_t [beam_pkg::NUM_ANT*beam_pkg::NUM_BEAM-1:0] i_weights,

    // beam sums out, two cycles after the RE
    output logic                        o_valid,
    output logic                        o_sym_start,
    output beam_pkg::beam_sum_t [beam_pkg::NUM_BEAM-1:0] o_sum
);

    logic signed [beam_pkg::SAMPLE_W+beam_pkg::WEIGHT_W-1:0]
        prod_q [beam_pkg::NUM_BEAM][beam_pkg::NUM_ANT];   // stage 1 products
    beam_pkg::beam_sum_t sum_d [beam_pkg::NUM_BEAM];
    logic [1:0] valid_sr;
    logic [1:0] sym_sr;

    // ----------------------------------------------------------------------
    // stage 1, one product per beam and antenna
    // ----------------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        for (int b = 0; b < beam_pkg::NUM_BEAM; b++) begin
            for (int a = 0; a < beam_pkg::NUM_ANT; a++) begin
                prod_q[b][a] <= $signed(i_ant_data[a]) *
                                $signed(i_weights[b*beam_pkg::NUM_ANT + a]);
            end
        end
    end

    // ----------------------------------------------------------------------
    // stage 2, sum over antennas
    // ----------------------------------------------------------------------
    always_comb begin
        for (int b = 0; b < beam_pkg::NUM_BEAM; b++) begin
            sum_d[b] = '0;
            for (int a = 0; a < beam_pkg::NUM_ANT; a++) begin
                sum_d[b] = sum_d[b] + beam_pkg::beam_sum_t'(prod_q[b][a]);  // sign extend
            end
        end
    end

    always_ff @(posedge i_clk) begin
        for (int b = 0; b < beam_pkg::NUM_BEAM; b++) begin
            o_sum[b] <= sum_d[b];
        end
    end

    // control flags follow the data through both stages
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            valid_sr <= '0;
            sym_sr   <= '0;
        end else begin
            valid_sr <= {valid_sr[0], i_valid};
            sym_sr   <= {sym_sr[0], i_sym_start};
        end
    end

    assign o_valid     = valid_sr[1];
    assign o_sym_start = sym_sr[1];

endmodule

`default_nettype wire

// File: source/beam_pkg.sv
`default_nettype none

package beam_pkg;

    // ----------------------------------------------------------------------
    // array dimensions
    // ----------------------------------------------------------------------
    localparam int NUM_ANT  = 4;    // antennas per RE
    localparam int NUM_BEAM = 8;    // candidate beams
    localparam int SAMPLE_W = 16;   // antenna sample bits
    localparam int WEIGHT_W = 8;    // codeword weight bits

    // ----------------------------------------------------------------------
    // data types
    // ----------------------------------------------------------------------
    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic signed [WEIGHT_W-1:0] weight_t;

    // one product plus two guard bits for the four antenna terms
    typedef logic signed [SAMPLE_W+WEIGHT_W+1:0] beam_sum_t;

    // magnitude of a beam sum grown by four bits for 16 REs
    typedef logic [SAMPLE_W+WEIGHT_W+5:0] energy_t;

    typedef logic [$clog2(NUM_BEAM)-1:0] beam_idx_t;
    typedef logic [$clog2(NUM_ANT*NUM_BEAM)-1:0] cw_addr_t;   // beam * NUM_ANT + ant

endpackage

`default_nettype wire

// File: source/beam_select.sv
`timescale 1ns/1ps
`default_nettype none

module beam_select (
    input  wire                         i_clk,
    input  wire                         i_reset,

    input  wire                         i_valid,
    input  wire rbg_pkg::rbg_num_t      i_rbg_num,
    input  wire beam_pkg::energy_t [beam_pkg::NUM_BEAM-1:0] i_energy,

    output logic                        o_valid,
    output rbg_pkg::rbg_num_t           o_rbg_num,
    output beam_pkg::beam_idx_t         o_beam_idx,
    output beam_pkg::energy_t           o_beam_energy
);

    // heap ordered tree, leaves from NUM_BEAM-1 up
    beam_pkg::energy_t   node_e [2*beam_pkg::NUM_BEAM-1];
    beam_pkg::beam_idx_t node_i [2*beam_pkg::NUM_BEAM-1];
    beam_pkg::energy_t   energy_q [beam_pkg::NUM_BEAM];
    logic                max_ok;

    // ----------------------------------------------------------------------
    // comparison tree
    // ----------------------------------------------------------------------
    always_comb begin
        for (int i = 0; i < beam_pkg::NUM_BEAM; i++) begin
            node_e[beam_pkg::NUM_BEAM-1+i] = i_energy[i];
            node_i[beam_pkg::NUM_BEAM-1+i] = beam_pkg::beam_idx_t'(i);
        end
        for (int n = beam_pkg::NUM_BEAM-2; n >= 0; n--) begin
            // left child holds the lower beams, so ties stay left
            if (node_e[2*n+2] > node_e[2*n+1]) begin
                node_e[n] = node_e[2*n+2];
                node_i[n] = node_i[2*n+2];
            end else begin
                node_e[n] = node_e[2*n+1];
                node_i[n] = node_i[2*n+1];
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
        if (i_valid) begin
            o_rbg_num     <= i_rbg_num;
            o_beam_idx    <= node_i[0];
            o_beam_energy <= node_e[0];
            for (int i = 0; i < beam_pkg::NUM_BEAM; i++) begin
                energy_q[i] <= i_energy[i];     // inputs kept for the check below
            end
        end
    end

    // ----------------------------------------------------------------------
    // checks
    // ----------------------------------------------------------------------
    always_comb begin
        max_ok = 1'b1;
        for (int i = 0; i < beam_pkg::NUM_BEAM; i++) begin
            if (energy_q[i] > o_beam_energy) begin
                max_ok = 1'b0;
            end
        end
    end

    a_winner_is_max : assert property (
        @(posedge i_clk) disable iff (i_reset) o_valid |-> max_ok
    );

endmodule

`default_nettype wire

// File: source/cw_bank.sv
`timescale 1ns/1ps
`default_nettype none

module cw_bank (
    input  wire                         i_clk,
    input  wire                         i_reset,

    // weight write port
    input  wire                         i_cw_wr,
    input  wire beam_pkg::cw_addr_t     i_cw_addr,
    input  wire beam_pkg::weight_t      i_cw_data,

    // all weights, entry beam * NUM_ANT + ant
    output beam_pkg::weight_t [beam_pkg::NUM_ANT*beam_pkg::NUM_BEAM-1:0] o_weights
);

    // ----------------------------------------------------------------------
    // weight registers
    // ----------------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_weights <= '0;                        // all beams null after reset
        end else if (i_cw_wr) begin
            o_weights[i_cw_addr] <= i_cw_data;      // visible to the MAC next cycle
        end
    end

    // ----------------------------------------------------------------------
    // checks
    // ----------------------------------------------------------------------
    // writes must carry a known address inside the bank of NUM_BEAM x NUM_ANT weights
    a_cw_addr_range : assert property (
        @(posedge i_clk) disable iff (i_reset)
        i_cw_wr |-> (!$isunknown(i_cw_addr) &&
                     (int'(i_cw_addr) < beam_pkg::NUM_ANT * beam_pkg::NUM_BEAM))
    );

endmodule

`default_nettype wire

// File: source/pdsch_beam_reduce.sv
`timescale 1ns/1ps
`default_nettype none

module pdsch_beam_reduce (
    input  wire                         i_clk,
    input  wire                         i_reset,

    // codeword load
    input  wire                         i_cw_wr,
    input  wire beam_pkg::cw_addr_t     i_cw_addr,
    input  wire beam_pkg::weight_t      i_cw_data,

    // RE stream, no back pressure
    input  wire                         i_valid,
    input  wire                         i_sym_start,
    input  wire rbg_pkg::rbg_size_e     i_rbg_size,
    input  wire beam_pkg::sample_t [beam_pkg::NUM_ANT-1:0] i_ant_data,

    // best beam per RBG, 4 cycles after its last RE
    output logic                        o_valid,
    output rbg_pkg::rbg_num_t           o_rbg_num,
    output beam_pkg::beam_idx_t         o_beam_idx,
    output beam_pkg::energy_t           o_beam_energy
);

    beam_pkg::weight_t [beam_pkg::NUM_ANT*beam_pkg::NUM_BEAM-1:0] weights;

    logic                                           mac_valid;
    logic                                           mac_sym_start;
    beam_pkg::beam_sum_t [beam_pkg::NUM_BEAM-1:0]   mac_sum;

    logic                                           acc_valid;
    rbg_pkg::rbg_num_t                              acc_rbg_num;
    beam_pkg::energy_t [beam_pkg::NUM_BEAM-1:0]     acc_energy;

    rbg_pkg::rbg_size_e rbg_size_d1;
    rbg_pkg::rbg_size_e rbg_size_d2;

    // ----------------------------------------------------------------------
    // size code rides beside the two MAC stages
    // ----------------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        rbg_size_d1 <= i_rbg_size;
        rbg_size_d2 <= rbg_size_d1;     // lines up with mac_sym_start
    end

    // ----------------------------------------------------------------------
    // datapath
    // ----------------------------------------------------------------------
    cw_bank u_cw_bank (
        .i_clk(i_clk), .i_reset(i_reset),
        .i_cw_wr(i_cw_wr), .i_cw_addr(i_cw_addr), .i_cw_data(i_cw_data),
        .o_weights(weights)
    );

    beam_mac u_beam_mac (
        .i_clk(i_clk), .i_reset(i_reset),
        .i_valid(i_valid), .i_sym_start(i_sym_start), .i_ant_data(i_ant_data),
        .i_weights(weights),
        .o_valid(mac_valid), .o_sym_start(mac_sym_start), .o_sum(mac_sum)
    );

    rbg_accumulator u_rbg_accumulator (
        .i_clk(i_clk), .i_reset(i_reset),
        .i_valid(mac_valid), .i_sym_start(mac_sym_start), .i_rbg_size(rbg_size_d2),
        .i_sum(mac_sum),
        .o_valid(acc_valid), .o_rbg_num(acc_rbg_num), .o_energy(acc_energy)
    );

    beam_select u_beam_select (
        .i_clk(i_clk), .i_reset(i_reset),
        .i_valid(acc_valid), .i_rbg_num(acc_rbg_num), .i_energy(acc_energy),
        .o_valid(o_valid), .o_rbg_num(o_rbg_num),
        .o_beam_idx(o_beam_idx), .o_beam_energy(o_beam_energy)
    );

endmodule

`default_nettype wire

// File: source/rbg_accumulator.sv
`timescale 1ns/1ps
`default_nettype none

module rbg_accumulator (
    input  wire                         i_clk,
    input  wire                         i_reset,

    // beam sums from the MAC, size code aligned with them
    input  wire                         i_valid,
    input  wire                         i_sym_start,
    input  wire rbg_pkg::rbg_size_e     i_rbg_size,
    input  wire beam_pkg::beam_sum_t [beam_pkg::NUM_BEAM-1:0] i_sum,

    // per-beam energy of one finished RBG
    output logic                        o_valid,
    output rbg_pkg::rbg_num_t           o_rbg_num,
    output beam_pkg::energy_t [beam_pkg::NUM_BEAM-1:0] o_energy
);

    rbg_pkg::rbg_size_e size_q;     // size of the current symbol
    rbg_pkg::rbg_size_e size_cur;
    rbg_pkg::re_cnt_t   re_cnt_q;   // next RE index inside the RBG
    rbg_pkg::re_cnt_t   re_idx;
    rbg_pkg::re_cnt_t   last_idx;
    rbg_pkg::rbg_num_t  rbg_num_q;
    rbg_pkg::rbg_num_t  rbg_cur;
    logic               first_re;
    logic               last_re;

    logic [$bits(beam_pkg::beam_sum_t)-1:0] mag [beam_pkg::NUM_BEAM];
    beam_pkg::energy_t acc_q [beam_pkg::NUM_BEAM];
    beam_pkg::energy_t acc_d [beam_pkg::NUM_BEAM];

    // ----------------------------------------------------------------------
    // RE position within the RBG
    // ----------------------------------------------------------------------
    // a symbol start takes the new size and restarts at RE 0 right away
    always_comb begin
        size_cur = i_sym_start ? i_rbg_size : size_q;
        case (size_cur)
            rbg_pkg::RBG_SIZE_8:  last_idx = rbg_pkg::re_cnt_t'(rbg_pkg::RBG_RE_8 - 1);
            rbg_pkg::RBG_SIZE_16: last_idx = rbg_pkg::re_cnt_t'(rbg_pkg::RBG_RE_16 - 1);
            default:              last_idx = rbg_pkg::re_cnt_t'(rbg_pkg::RBG_RE_4 - 1);
        endcase
        re_idx   = i_sym_start ? '0 : re_cnt_q;
        rbg_cur  = i_sym_start ? '0 : rbg_num_q;   // partial RBG dropped
        first_re = (re_idx == '0);
        last_re  = (re_idx == last_idx);
    end

    // ----------------------------------------------------------------------
    // magnitude accumulation
    // ----------------------------------------------------------------------
    always_comb begin
        for (int b = 0; b < beam_pkg::NUM_BEAM; b++) begin
            // most negative sum wraps onto its own magnitude as unsigned
            mag[b]   = i_sum[b][$bits(beam_pkg::beam_sum_t)-1] ? -i_sum[b] : i_sum[b];
            acc_d[b] = (first_re ? '0 : acc_q[b]) + beam_pkg::energy_t'(mag[b]);
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            for (int b = 0; b < beam_pkg::NUM_BEAM; b++) begin
                acc_q[b] <= acc_d[b];
            end
        end
        if (i_valid && last_re) begin
            for (int b = 0; b < beam_pkg::NUM_BEAM; b++) begin
                o_energy[b] <= acc_d[b];    // totals include the last RE
            end
            o_rbg_num <= rbg_cur;
        end
    end

    // ----------------------------------------------------------------------
    // counters
    // ----------------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            size_q    <= rbg_pkg::RBG_SIZE_4;
            re_cnt_q  <= '0;
            rbg_num_q <= '0;
            o_valid   <= 1'b0;
        end else begin
            o_valid <= i_valid & last_re;   // single cycle per RBG
            if (i_valid) begin
                if (i_sym_start) begin
                    size_q <= i_rbg_size;
                end
                re_cnt_q  <= last_re ? '0 : re_idx + 1'b1;
                rbg_num_q <= last_re ? rbg_cur + 1'b1 : rbg_cur;
            end
        end
    end

    // ----------------------------------------------------------------------
    // checks
    // ----------------------------------------------------------------------
    a_sym_start_valid : assert property (
        @(posedge i_clk) disable iff (i_reset) i_sym_start |-> i_valid
    );

    a_size_not_rsvd : assert property (
        @(posedge i_clk) disable iff (i_reset) size_q != rbg_pkg::RBG_SIZE_RSVD
    );

endmodule

`default_nettype wire

// File: source/rbg_pkg.sv
`default_nettype none

package rbg_pkg;

    // ----------------------------------------------------------------------
    // RBG size code as carried on the RE stream
    // ----------------------------------------------------------------------
    typedef enum logic [1:0] {
        RBG_SIZE_4    = 2'd0,
        RBG_SIZE_8    = 2'd1,
        RBG_SIZE_16   = 2'd2,
        RBG_SIZE_RSVD = 2'd3    // reserved, never sent
    } rbg_size_e;

    localparam int RBG_RE_MAX = 16;   // longest RBG in REs

    // REs per RBG for each size code
    localparam int RBG_RE_4  = 4;
    localparam int RBG_RE_8  = 8;
    localparam int RBG_RE_16 = 16;

    typedef logic [$clog2(RBG_RE_MAX)-1:0] re_cnt_t;   // RE index inside an RBG
    typedef logic [7:0] rbg_num_t;                     // RBG number within a symbol

endpackage

`default_nettype wire
